//--- hdl/memtest_pkg.sv
`default_nettype none

package memtest_pkg;

    // ----------------------------------------------------------------------
    // memory geometry
    // ----------------------------------------------------------------------
    localparam int ADDR_W = 10;
    localparam int DATA_W = 16;
    localparam int DEPTH  = 1 << ADDR_W;           // one word per address.

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // ----------------------------------------------------------------------
    // expected pattern
    // ----------------------------------------------------------------------
    // Every word should read back as its own address.
    // The bits above the address are always zero.
    localparam int PAD_W = DATA_W - ADDR_W;
    localparam logic [PAD_W-1:0] PAD = '0;          // upper bits of every good word.

endpackage

`default_nettype wire

//--- hdl/report_pkg.sv
`default_nettype none

package report_pkg;

    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [7:0]        cnt_t;             // error count, saturates.
    typedef logic [2:0]        idx_t;             // byte position inside a record.

    localparam cnt_t CNT_MAX = 8'hff;

    // ----------------------------------------------------------------------
    // record layout
    // ----------------------------------------------------------------------
    localparam byte_t ERR_MARK  = 8'hee;
    localparam byte_t DONE_MARK = 8'hdd;
    localparam int    ERR_LEN   = 7;              // mark, address, expected, actual.
    localparam int    DONE_LEN  = 2;              // mark and count.

endpackage

`default_nettype wire

//--- hdl/test_ram.sv
`timescale 1ns/100ps
`default_nettype none

module test_ram (
    input  logic               clk,
    input  memtest_pkg::addr_t rd_addr,
    output memtest_pkg::word_t rd_data,
    input  logic               wr_en,
    input  memtest_pkg::addr_t wr_addr,
    input  memtest_pkg::word_t wr_data
);
    import memtest_pkg::*;

    word_t mem [DEPTH];

    // power-up image holds each word's own address.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];                  // one clock of read latency.
    end

endmodule

`default_nettype wire

//--- hdl/addr_sweep.sv
`timescale 1ns/100ps
`default_nettype none

module addr_sweep #(
    parameter int unsigned MAX_ADDRESS = 1023
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  memtest_pkg::addr_t load_addr,
    input  logic               next,
    output memtest_pkg::addr_t addr,
    output logic               is_last
);
    import memtest_pkg::*;

    localparam addr_t LAST = addr_t'(MAX_ADDRESS);

    addr_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_addr;                   // load wins over advance.
        end else if (next && count != LAST) begin
            count <= count + 1'b1;
        end
    end

    assign addr    = count;
    assign is_last = (count == LAST);

endmodule

`default_nettype wire

//--- hdl/sweep_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module sweep_fsm #(
    parameter int unsigned MAX_ADDRESS = 1023
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               busy,
    output logic               addr_load,
    output logic               addr_next,
    output memtest_pkg::addr_t load_addr,
    input  memtest_pkg::addr_t addr,
    input  logic               is_last,
    input  memtest_pkg::word_t rd_data,
    output logic               err_event,
    output logic               done_event,
    output memtest_pkg::addr_t err_addr,
    output memtest_pkg::word_t err_expected,
    output memtest_pkg::word_t err_actual,
    output report_pkg::cnt_t   err_count,
    input  logic               report_idle
);
    import memtest_pkg::*;
    import report_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SWEEP,
        S_WAIT_REPORT,
        S_FINISH,
        S_WAIT_DONE
    } state_t;

    state_t state, state_next;
    logic   cmp_valid;                            // a read is due for compare.
    addr_t  cmp_addr;                             // address of that read.
    word_t  expected;
    logic   mismatch;

    assign expected = {PAD, cmp_addr};
    assign mismatch = cmp_valid && (rd_data != expected);

    // ----------------------------------------------------------------------
    // next state and strobes
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        addr_load  = 1'b0;
        addr_next  = 1'b0;
        err_event  = 1'b0;
        done_event = 1'b0;
        case (state)
            S_IDLE: begin
                if (start) begin
                    addr_load  = 1'b1;            // rewind to address zero.
                    state_next = S_SWEEP;
                end
            end
            S_SWEEP: begin
                if (mismatch) begin
                    err_event  = 1'b1;            // freeze, the read in flight is dropped.
                    state_next = S_WAIT_REPORT;
                end else if (is_last) begin
                    state_next = S_FINISH;
                end else begin
                    addr_next = 1'b1;
                end
            end
            S_WAIT_REPORT: begin
                if (report_idle) begin
                    if (cmp_addr == addr_t'(MAX_ADDRESS)) begin
                        state_next = S_FINISH;
                    end else begin
                        addr_load  = 1'b1;
                        state_next = S_SWEEP;
                    end
                end
            end
            S_FINISH: begin
                if (mismatch) begin
                    err_event  = 1'b1;
                    state_next = S_WAIT_REPORT;
                end else begin
                    done_event = 1'b1;
                    state_next = S_WAIT_DONE;
                end
            end
            default: begin
                if (report_idle) begin
                    state_next = S_IDLE;          // done record has left the line.
                end
            end
        endcase
    end

    assign busy         = (state != S_IDLE);
    assign load_addr    = (state == S_IDLE) ? addr_t'(0) : addr_t'(cmp_addr + 1'b1);
    assign err_addr     = cmp_addr;
    assign err_expected = expected;
    assign err_actual   = rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cmp_valid <= 1'b0;
            err_count <= '0;
        end else begin
            state     <= state_next;
            cmp_valid <= (state == S_SWEEP) && !mismatch;
            if (state == S_IDLE && start) begin
                err_count <= '0;
            end else if (err_event && err_count != CNT_MAX) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_SWEEP && !mismatch) begin
            cmp_addr <= addr;                     // tracks the address being read.
        end
    end

endmodule

`default_nettype wire

//--- hdl/error_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module error_reporter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               err_event,
    input  logic               done_event,
    input  memtest_pkg::addr_t err_addr,
    input  memtest_pkg::word_t err_expected,
    input  memtest_pkg::word_t err_actual,
    input  report_pkg::cnt_t   err_count,
    output logic               tx_valid,
    output report_pkg::byte_t  tx_byte,
    input  logic               tx_accepted,
    output logic               report_idle
);
    import memtest_pkg::*;
    import report_pkg::*;

    logic  active;
    logic  is_err;                                // error record, else done record.
    idx_t  idx;
    idx_t  last_idx;
    word_t lat_addr;
    word_t lat_exp;
    word_t lat_act;
    cnt_t  lat_cnt;

    assign last_idx = is_err ? idx_t'(ERR_LEN - 1) : idx_t'(DONE_LEN - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            is_err <= 1'b0;
            idx    <= '0;
        end else if (!active) begin
            if (err_event || done_event) begin
                active <= 1'b1;
                is_err <= err_event;
                idx    <= '0;
            end
        end else if (tx_accepted) begin
            if (idx == last_idx) begin
                active <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && (err_event || done_event)) begin
            lat_addr <= {PAD, err_addr};          // high byte padded with zeros.
            lat_exp  <= err_expected;
            lat_act  <= err_actual;
            lat_cnt  <= err_count;
        end
    end

    // ----------------------------------------------------------------------
    // byte select, high byte first
    // ----------------------------------------------------------------------
    always_comb begin
        if (is_err) begin
            case (idx)
                3'd0:    tx_byte = ERR_MARK;
                3'd1:    tx_byte = lat_addr[15:8];
                3'd2:    tx_byte = lat_addr[7:0];
                3'd3:    tx_byte = lat_exp[15:8];
                3'd4:    tx_byte = lat_exp[7:0];
                3'd5:    tx_byte = lat_act[15:8];
                default: tx_byte = lat_act[7:0];
            endcase
        end else begin
            tx_byte = (idx == '0) ? DONE_MARK : lat_cnt;
        end
    end

    assign tx_valid    = active;
    assign report_idle = !active;

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
    parameter int unsigned CLKS_PER_BIT = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_valid,
    input  report_pkg::byte_t tx_byte,
    output logic              tx_accepted,
    output logic              tx
);
    import report_pkg::*;

    localparam int FRAME_W = BYTE_W + 2;         // start, data, stop.
    localparam int TIMER_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int COUNT_W = $clog2(FRAME_W);

    logic               sending;
    logic [FRAME_W-1:0] shifter;
    logic [TIMER_W-1:0] timer;
    logic [COUNT_W-1:0] bit_cnt;
    logic               bit_end;
    logic               frame_end;

    assign bit_end   = sending && (timer == TIMER_W'(CLKS_PER_BIT - 1));
    assign frame_end = bit_end && (bit_cnt == COUNT_W'(FRAME_W - 1));

    // The byte is acknowledged as the stop bit ends.
    // The sender holds it until then, so an idle reporter means an idle line.
    assign tx_accepted = frame_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sending <= 1'b0;
            shifter <= '1;                        // line idles high.
            timer   <= '0;
            bit_cnt <= '0;
        end else if (!sending) begin
            if (tx_valid) begin
                sending <= 1'b1;
                shifter <= {1'b1, tx_byte, 1'b0}; // lsb goes out first.
                timer   <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            timer <= '0;
            if (frame_end) begin
                sending <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                shifter <= {1'b1, shifter[FRAME_W-1:1]};
            end
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign tx = shifter[0];

endmodule

`default_nettype wire

//--- hdl/memtest_top.sv
`timescale 1ns/100ps
`default_nettype none

module memtest_top #(
    parameter int unsigned MAX_ADDRESS  = 1023,
    parameter int unsigned CLKS_PER_BIT = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               wr_en,
    input  memtest_pkg::addr_t wr_addr,
    input  memtest_pkg::word_t wr_data,
    output logic               tx,
    output logic               busy
);
    import memtest_pkg::*;
    import report_pkg::*;

    // ----------------------------------------------------------------------
    // sweep and memory
    // ----------------------------------------------------------------------
    logic  addr_load;
    logic  addr_next;
    addr_t load_addr;
    addr_t rd_addr;
    logic  is_last;
    word_t rd_data;

    // ----------------------------------------------------------------------
    // report path
    // ----------------------------------------------------------------------
    logic  err_event;
    logic  done_event;
    addr_t err_addr;
    word_t err_expected;
    word_t err_actual;
    cnt_t  err_count;
    logic  report_idle;
    logic  tx_valid;
    byte_t tx_byte;
    logic  tx_accepted;

    addr_sweep #(
        .MAX_ADDRESS(MAX_ADDRESS)
    ) sweep0 (
        .clk(clk),
        .rst_n(rst_n),
        .load(addr_load),
        .load_addr(load_addr),
        .next(addr_next),
        .addr(rd_addr),
        .is_last(is_last)
    );

    test_ram ram0 (
        .clk(clk),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    sweep_fsm #(
        .MAX_ADDRESS(MAX_ADDRESS)
    ) fsm0 (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .busy(busy),
        .addr_load(addr_load),
        .addr_next(addr_next),
        .load_addr(load_addr),
        .addr(rd_addr),
        .is_last(is_last),
        .rd_data(rd_data),
        .err_event(err_event),
        .done_event(done_event),
        .err_addr(err_addr),
        .err_expected(err_expected),
        .err_actual(err_actual),
        .err_count(err_count),
        .report_idle(report_idle)
    );

    error_reporter reporter0 (
        .clk(clk),
        .rst_n(rst_n),
        .err_event(err_event),
        .done_event(done_event),
        .err_addr(err_addr),
        .err_expected(err_expected),
        .err_actual(err_actual),
        .err_count(err_count),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte),
        .tx_accepted(tx_accepted),
        .report_idle(report_idle)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart0 (
        .clk(clk),
        .rst_n(rst_n),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte),
        .tx_accepted(tx_accepted),
        .tx(tx)
    );

endmodule

`default_nettype wire

//--- bench/memtest_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module memtest_asserts #(
    parameter int unsigned MAX_ADDRESS = 1023
) (
    input logic               clk,
    input logic               rst_n,
    input logic               tx,
    input logic               busy,
    input logic               tx_valid,
    input logic               tx_accepted,
    input report_pkg::byte_t  tx_byte,
    input memtest_pkg::addr_t rd_addr
);
    import memtest_pkg::*;

    // the line rests high whenever no pass is running.
    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
        else $error("tx low while busy is low");

    byte_held: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_accepted |=> tx_valid && $stable(tx_byte))
        else $error("tx byte dropped or changed before acceptance");

    addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr <= addr_t'(MAX_ADDRESS))
        else $error("sweep address beyond the last address");

endmodule

bind memtest_top memtest_asserts #(
    .MAX_ADDRESS(MAX_ADDRESS)
) asserts0 (
    .clk(clk),
    .rst_n(rst_n),
    .tx(tx),
    .busy(busy),
    .tx_valid(tx_valid),
    .tx_accepted(tx_accepted),
    .tx_byte(tx_byte),
    .rd_addr(rd_addr)
);

`default_nettype wire

//--- bench/memtest_tb.sv
`timescale 1ns/100ps
`default_nettype none

module memtest_tb;
    import memtest_pkg::*;
    import report_pkg::*;

    localparam int MAX_ADDRESS    = 1000;         // the top words of the RAM stay out of the sweep.
    localparam int CLKS_PER_BIT   = 4;
    localparam int NUM_PASSES     = 6;
    localparam int MAX_ERRORS     = 24;           // most bad words alive in any one pass.
    localparam int BYTE_CLKS      = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES =
        NUM_PASSES * (MAX_ADDRESS + 1 + 9 * BYTE_CLKS * MAX_ERRORS) + 2000;

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;
    logic  tx;
    logic  busy;

    integer seed;
    int     errors;
    int     checks;
    int     rx_count;
    word_t  model [DEPTH];                        // what the RAM should hold.
    byte_t  exp_q [$];                            // report bytes still due on tx.

    memtest_top #(
        .MAX_ADDRESS(MAX_ADDRESS),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .tx(tx),
        .busy(busy)
    );

    always #4 clk = ~clk;                         // 8 ns period.

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic write_word(input addr_t a, input word_t d);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        model[a] = d;
    endtask

    task automatic corrupt_word(input addr_t a);
        logic [31:0] r;
        word_t       d;
        r = $random(seed);
        d = r[15:0];
        if (d == word_t'(a)) begin
            d = ~d;                               // make sure the word really goes bad.
        end
        write_word(a, d);
    endtask

    task automatic random_writes(input int n);
        logic [31:0] r;
        addr_t       a;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            a = addr_t'(r % (MAX_ADDRESS + 1));
            r = $random(seed);
            write_word(a, r[15:0]);
        end
    endtask

    // restores bad words to their own address, all of them or every other one.
    task automatic repair_words(input bit every_one);
        addr_t bad_q [$];
        for (int a = 0; a <= MAX_ADDRESS; a++) begin
            if (model[addr_t'(a)] !== word_t'(a)) begin
                bad_q.push_back(addr_t'(a));
            end
        end
        foreach (bad_q[i]) begin
            if (every_one || (i % 2) == 0) begin
                write_word(bad_q[i], word_t'(bad_q[i]));
            end
        end
    endtask

    task automatic build_expected();
        int    bad;
        word_t good;
        word_t got;
        bad = 0;
        for (int a = 0; a <= MAX_ADDRESS; a++) begin
            good = word_t'(a);
            got  = model[addr_t'(a)];
            if (got !== good) begin
                bad++;
                exp_q.push_back(ERR_MARK);
                exp_q.push_back(good[15:8]);      // address, zero-extended.
                exp_q.push_back(good[7:0]);
                exp_q.push_back(good[15:8]);      // expected pattern.
                exp_q.push_back(good[7:0]);
                exp_q.push_back(got[15:8]);
                exp_q.push_back(got[7:0]);
            end
        end
        exp_q.push_back(DONE_MARK);
        exp_q.push_back((bad > 255) ? 8'hff : byte_t'(bad));
        $display("pass at %0t: %0d bad words expected", $time, bad);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_pass(input bit extra_start);
        logic [31:0] r;
        build_expected();
        check_bit("tx", tx, 1'b1);
        pulse_start();
        check_bit("busy", busy, 1'b1);
        if (extra_start) begin
            r = $random(seed);
            repeat (10 + (r % 100)) @(posedge clk);
            pulse_start();                        // must not restart the pass.
        end
        while (busy === 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
        checks++;
        if (exp_q.size() != 0) begin
            errors++;
            $display("error %0t: %0d report bytes never arrived on tx", $time, exp_q.size());
            exp_q.delete();
        end
        check_bit("tx", tx, 1'b1);
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d errors, %0d bytes decoded", checks, errors, rx_count);
    endtask

    // ----------------------------------------------------------------------
    // serial decoder, samples tx near the middle of each bit
    // ----------------------------------------------------------------------
    initial begin : uart_decoder
        byte_t rx;
        byte_t want;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check_bit("tx start bit", tx, 1'b0);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx[i] = tx;                   // lsb arrives first.
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_bit("tx stop bit", tx, 1'b1);
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error %0t: byte %02h sent on tx with no report due", $time, rx);
                end else begin
                    want = exp_q.pop_front();
                    checks++;
                    if (rx !== want) begin
                        errors++;
                        $display("error %0t: tx byte %0d is %02h, expected %02h",
                                 $time, rx_count, rx, want);
                    end
                end
                rx_count++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("timeout: the test did not end within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        seed     = 32'hda3e_9754;
        errors   = 0;
        checks   = 0;
        rx_count = 0;
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        for (int a = 0; a < DEPTH; a++) begin
            model[addr_t'(a)] = word_t'(a);
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("tx", tx, 1'b1);
        check_bit("busy", busy, 1'b0);

        run_pass(1'b0);                           // untouched RAM.
        random_writes(8);
        run_pass(1'b0);
        random_writes(6);
        run_pass(1'b1);
        repair_words(1'b0);                       // half the bad words come back.
        random_writes(4);
        run_pass(1'b0);
        repair_words(1'b1);
        run_pass(1'b0);
        corrupt_word(addr_t'(0));
        corrupt_word(addr_t'(1));
        corrupt_word(addr_t'(MAX_ADDRESS - 1));
        corrupt_word(addr_t'(MAX_ADDRESS));
        run_pass(1'b1);

        print_summary();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/memtest_pkg.sv
hdl/report_pkg.sv
hdl/test_ram.sv
hdl/addr_sweep.sv
hdl/sweep_fsm.sv
hdl/error_reporter.sv
hdl/uart_tx.sv
hdl/memtest_top.sv
bench/memtest_asserts.sv
bench/memtest_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := memtest_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
